/* Bender.yml */
package:
  name: fetch_unit

sources:
  - rv_isa_pkg.sv
  - fetch_pkg.sv
  - skid_buffer.sv
  - fetch_req_ctrl.sv
  - predecoder.sv
  - branch_tracker.sv
  - fetch_unit.sv
  - target: simulation
    files:
      - tb_fetch.sv

/* branch_tracker.sv */
module branch_tracker import rv_isa_pkg::*, fetch_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid_i,
    input  fetch_pkt_t       pkt_i,
    input  redirect_t        seq_next_i,
    input  logic [XLEN-1:0]  alt_pc_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    output fetch_pkt_t       out_pkt_o,
    input  logic             out_ready_i,
    output redirect_t        next_o,
    output redirect_t        redirect_o,
    output logic             flush_o,
    input  resolve_t         resolve_i,
    output logic             fence_o,
    input  logic             fence_done_i,
    output logic [CNT_W-1:0] pred_hit_cnt_o,
    output logic [CNT_W-1:0] pred_miss_cnt_o
);

    typedef enum logic [1:0] {
        ST_OPEN,
        ST_BRANCH,  // branch out, next word held back
        ST_JUMP,    // jalr or system, waiting on target
        ST_FENCE
    } trk_state_e;

    trk_state_e      state_q;
    logic            pred_q;      // prediction of the open branch
    logic [XLEN-1:0] alt_pc_q;
    logic [XLEN-1:0] fence_pc_q;
    logic            resolve_br;
    logic            hit;
    logic            release_pkt;
    logic            accept;

    assign resolve_br  = (state_q == ST_BRANCH) && resolve_i.valid;
    assign hit         = (resolve_i.taken == pred_q);
    assign release_pkt = (state_q == ST_OPEN) || (resolve_br && hit);

    assign in_ready_o  = release_pkt & out_ready_i;
    assign out_valid_o = release_pkt & in_valid_i;
    assign out_pkt_o   = pkt_i;
    assign accept      = in_valid_i & in_ready_o;

    assign next_o.valid = accept & seq_next_i.valid;
    assign next_o.pc    = seq_next_i.pc;

    assign flush_o = resolve_br & ~hit;  // held word is wrong path
    assign fence_o = (state_q == ST_FENCE);

    always_comb begin
        redirect_o.valid = 1'b0;
        redirect_o.pc    = alt_pc_q;
        case (state_q)
            ST_BRANCH: redirect_o.valid = resolve_i.valid & ~hit;
            ST_JUMP: begin
                redirect_o.valid = resolve_i.valid;
                redirect_o.pc    = resolve_i.target;
            end
            ST_FENCE: begin
                redirect_o.valid = fence_done_i;
                redirect_o.pc    = fence_pc_q;
            end
            default: redirect_o.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= ST_OPEN;
            pred_q          <= 1'b0;
            pred_hit_cnt_o  <= '0;
            pred_miss_cnt_o <= '0;
        end else begin
            if (resolve_br) begin
                if (hit) begin
                    pred_hit_cnt_o <= pred_hit_cnt_o + 1'b1;
                end else begin
                    pred_miss_cnt_o <= pred_miss_cnt_o + 1'b1;
                end
            end
            if (resolve_br || redirect_o.valid) begin
                state_q <= ST_OPEN;
            end
            // a packet released on a hit sets the next state itself
            if (accept) begin
                case (pkt_i.cls)
                    CLS_BRANCH: begin
                        state_q <= ST_BRANCH;
                        pred_q  <= pkt_i.pred_taken;
                    end
                    CLS_JALR, CLS_SYSTEM: state_q <= ST_JUMP;
                    CLS_FENCE_I:          state_q <= ST_FENCE;
                    default:              state_q <= ST_OPEN;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alt_pc_q   <= alt_pc_i;
            fence_pc_q <= pkt_i.pc + XLEN'(4);
        end
    end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    import rv_isa_pkg::*;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;
    localparam int CNT_W = 32;  // perf counter width

    // word returned by memory together with its address
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [31:0]     instr;
    } mem_rsp_t;

    // packet handed to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        instr_class_e    cls;
        logic            pred_taken;
    } fetch_pkt_t;

    // branch / jump outcome from execute
    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [XLEN-1:0] target;
    } resolve_t;

    // next fetch address
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

/* fetch_req_ctrl.sv */
module fetch_req_ctrl import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    output logic            mem_req_o,
    output logic [XLEN-1:0] mem_addr_o,
    input  logic            mem_gnt_i,
    input  logic            mem_rsp_valid_i,
    input  logic [31:0]     mem_rdata_i,
    output logic            rsp_valid_o,
    output mem_rsp_t        rsp_o,
    input  logic            rsp_ready_i,
    input  redirect_t       next_i,
    input  redirect_t       redirect_i
);

    typedef enum logic [1:0] {
        S_IDLE,   // just out of reset
        S_REQ,    // request held until grant
        S_AWAIT,  // granted, response outstanding
        S_NEXT    // word delivered, waiting for next address
    } req_state_e;

    req_state_e      state_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] pend_pc_q;  // redirect target while a read is in flight
    logic            epoch_q;
    logic            epoch_d;
    logic            req_epoch_q;  // tag of the current read
    logic            rsp_valid_q;
    mem_rsp_t        rsp_q;
    logic            drop_rsp;

    assign mem_req_o   = (state_q == S_REQ);
    assign mem_addr_o  = addr_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    assign epoch_d = epoch_q ^ redirect_i.valid;

    // old path, or the path changes under this response
    assign drop_rsp = (req_epoch_q != epoch_q) | redirect_i.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_IDLE;
            addr_q      <= RESET_PC;
            epoch_q     <= 1'b0;
            req_epoch_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            epoch_q <= epoch_d;
            if (rsp_valid_q && rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            if (redirect_i.valid) begin
                rsp_valid_q <= 1'b0;  // wrong-path word not yet handed on
            end

            case (state_q)
                S_IDLE: begin
                    state_q <= S_REQ;
                end
                S_REQ: begin
                    if (mem_gnt_i) begin
                        state_q <= S_AWAIT;
                    end
                end
                S_AWAIT: begin
                    if (mem_rsp_valid_i) begin
                        if (drop_rsp) begin
                            state_q     <= S_REQ;
                            addr_q      <= redirect_i.valid ? redirect_i.pc : pend_pc_q;
                            req_epoch_q <= epoch_d;
                        end else begin
                            rsp_q.addr  <= addr_q;
                            rsp_q.instr <= mem_rdata_i;
                            rsp_valid_q <= 1'b1;
                            state_q     <= S_NEXT;
                        end
                    end
                end
                S_NEXT: begin
                    if (redirect_i.valid) begin  // redirect wins over next
                        state_q     <= S_REQ;
                        addr_q      <= redirect_i.pc;
                        req_epoch_q <= epoch_d;
                    end else if (next_i.valid) begin
                        state_q     <= S_REQ;
                        addr_q      <= next_i.pc;
                        req_epoch_q <= epoch_q;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // remembered until the stale response has drained
    always_ff @(posedge clk) begin
        if (redirect_i.valid) begin
            pend_pc_q <= redirect_i.pc;
        end
    end

endmodule

/* fetch_stim.txt */
// @00 header: program words, outcome entries, expected hits, expected misses, expected packets
// @10 program words from pc 80000000 up; @40 outcomes: taken bit per branch, target per jump
@00
0000001a 0000000a 00000004 00000003 0000001c
@10
00108093 00300113 0080006f 00000013 // 00: addi, addi, jal +8, skipped word
00108093 00000013 fe209ce3 00208663 // 10: loop body, bne -8, beq +12
00000013 00208663 00300113 00000013 // 20: nop, beq +12, wrong path words
00c000ef 00000013 00000013 00008067 // 30: jal x1 +12, jalr x0 0(x1) at 3c
00000013 00000073 00000013 00000013 // 40: ecall at 44
0000100f fe209ce3 30200073 00000013 // 50: fence.i, bne -8, mret
00108093 0000006f                   // 60: addi, jal to itself
@40
00000001 00000001 00000000          // bne at 18: taken twice, then falls through
00000000                            // beq at 1c not taken
00000001                            // beq at 24 taken
80000044                            // jalr target
80000050                            // ecall target
00000001 00000000                   // bne at 54: taken once, then falls through
80000060                            // mret target

/* fetch_unit.f */
rv_isa_pkg.sv
fetch_pkg.sv
skid_buffer.sv
fetch_req_ctrl.sv
predecoder.sv
branch_tracker.sv
fetch_unit.sv
tb_fetch.sv

/* fetch_unit.sv */
module fetch_unit import fetch_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // instruction memory
    output logic             mem_req_o,
    output logic [XLEN-1:0]  mem_addr_o,
    input  logic             mem_gnt_i,
    input  logic             mem_rsp_valid_i,
    input  logic [31:0]      mem_rdata_i,
    // decode
    output logic             pkt_valid_o,
    output fetch_pkt_t       pkt_o,
    input  logic             pkt_ready_i,
    // execute and fence handshake
    input  resolve_t         resolve_i,
    output logic             fence_o,
    input  logic             fence_done_i,
    output logic [CNT_W-1:0] pred_hit_cnt_o,
    output logic [CNT_W-1:0] pred_miss_cnt_o
);

    logic            rsp_valid;
    mem_rsp_t        rsp;
    logic            rsp_ready;
    logic            dec_valid;
    mem_rsp_t        dec_rsp;
    logic            dec_ready;
    fetch_pkt_t      dec_pkt;
    redirect_t       seq_next;
    logic [XLEN-1:0] alt_pc;
    logic            trk_valid;
    fetch_pkt_t      trk_pkt;
    logic            trk_ready;
    redirect_t       next_pc;
    redirect_t       redirect;
    logic            flush;

    fetch_req_ctrl req_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_gnt_i       (mem_gnt_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rdata_i     (mem_rdata_i),
        .rsp_valid_o     (rsp_valid),
        .rsp_o           (rsp),
        .rsp_ready_i     (rsp_ready),
        .next_i          (next_pc),
        .redirect_i      (redirect)
    );

    skid_buffer #(.payload_t(mem_rsp_t)) rsp_buf (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (rsp_valid),
        .in_data_i   (rsp),
        .in_ready_o  (rsp_ready),
        .out_valid_o (dec_valid),
        .out_data_o  (dec_rsp),
        .out_ready_i (dec_ready),
        .flush_i     (flush)  // drops the held wrong-path word
    );

    predecoder predecoder_i (
        .rsp_i      (dec_rsp),
        .pkt_o      (dec_pkt),
        .seq_next_o (seq_next),
        .alt_pc_o   (alt_pc)
    );

    branch_tracker tracker_i (
        .clk             (clk),
        .rst             (rst),
        .in_valid_i      (dec_valid),
        .pkt_i           (dec_pkt),
        .seq_next_i      (seq_next),
        .alt_pc_i        (alt_pc),
        .in_ready_o      (dec_ready),
        .out_valid_o     (trk_valid),
        .out_pkt_o       (trk_pkt),
        .out_ready_i     (trk_ready),
        .next_o          (next_pc),
        .redirect_o      (redirect),
        .flush_o         (flush),
        .resolve_i       (resolve_i),
        .fence_o         (fence_o),
        .fence_done_i    (fence_done_i),
        .pred_hit_cnt_o  (pred_hit_cnt_o),
        .pred_miss_cnt_o (pred_miss_cnt_o)
    );

    // only architectural packets get here, never flushed
    skid_buffer #(.payload_t(fetch_pkt_t)) out_buf (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (trk_valid),
        .in_data_i   (trk_pkt),
        .in_ready_o  (trk_ready),
        .out_valid_o (pkt_valid_o),
        .out_data_o  (pkt_o),
        .out_ready_i (pkt_ready_i),
        .flush_i     (1'b0)
    );

endmodule

/* predecoder.sv */
module predecoder import rv_isa_pkg::*, fetch_pkg::*; (
    input  mem_rsp_t        rsp_i,
    output fetch_pkt_t      pkt_o,
    output redirect_t       seq_next_o,
    output logic [XLEN-1:0] alt_pc_o
);

    logic [31:0]           instr;
    logic [XLEN-1:0]       pc;
    logic [OPC_W-1:0]      opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT12_W-1:0]  funct12;
    instr_class_e          cls;
    logic [XLEN-1:0]       b_imm;
    logic [XLEN-1:0]       j_imm;
    logic [XLEN-1:0]       br_target;
    logic [XLEN-1:0]       jal_target;
    logic [XLEN-1:0]       seq_pc;
    logic                  taken;

    assign instr   = rsp_i.instr;
    assign pc      = rsp_i.addr;
    assign opcode  = instr[OPC_LSB +: OPC_W];
    assign funct3  = instr[FUNCT3_LSB +: FUNCT3_W];
    assign funct12 = instr[FUNCT12_LSB +: FUNCT12_W];

    always_comb begin
        cls = CLS_PLAIN;
        case (opcode)
            OPC_JAL:    cls = CLS_JAL;
            OPC_BRANCH: cls = CLS_BRANCH;
            OPC_JALR:   cls = CLS_JALR;
            OPC_SYSTEM: begin
                if (funct3 == FUNCT3_PRIV &&
                    (funct12 == FUNCT12_ECALL || funct12 == FUNCT12_MRET)) begin
                    cls = CLS_SYSTEM;
                end
            end
            OPC_MISC_MEM: begin
                if (funct3 == FUNCT3_FENCE_I) begin
                    cls = CLS_FENCE_I;
                end
            end
            default: cls = CLS_PLAIN;
        endcase
    end

    // B and J immediates
    assign b_imm = {{(XLEN-12){instr[IMM_SIGN]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{(XLEN-20){instr[IMM_SIGN]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign br_target  = pc + b_imm;
    assign jal_target = pc + j_imm;
    assign seq_pc     = pc + XLEN'(4);

    // backward taken, forward not taken
    assign taken = (cls == CLS_BRANCH) && (br_target < pc);

    assign pkt_o.pc         = pc;
    assign pkt_o.instr      = instr;
    assign pkt_o.cls        = cls;
    assign pkt_o.pred_taken = taken;

    // jalr, system and fence.i need outside help for the next pc
    assign seq_next_o.valid = (cls == CLS_PLAIN) || (cls == CLS_JAL) || (cls == CLS_BRANCH);
    assign seq_next_o.pc    = (cls == CLS_JAL) ? jal_target : (taken ? br_target : seq_pc);

    assign alt_pc_o = taken ? seq_pc : br_target;  // path not predicted

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_BRANCH   = 7'b110_0011;
    localparam logic [6:0] OPC_JAL      = 7'b110_1111;
    localparam logic [6:0] OPC_JALR     = 7'b110_0111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b111_0011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b000_1111;

    // funct3 values of interest
    localparam logic [2:0] FUNCT3_PRIV    = 3'b000;  // ecall, ebreak, mret...
    localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

    // funct12 for the privileged system instructions
    localparam logic [11:0] FUNCT12_ECALL = 12'h000;
    localparam logic [11:0] FUNCT12_MRET  = 12'h302;

    // field positions
    localparam int OPC_LSB     = 0;
    localparam int OPC_W       = 7;
    localparam int FUNCT3_LSB  = 12;
    localparam int FUNCT3_W    = 3;
    localparam int FUNCT12_LSB = 20;
    localparam int FUNCT12_W   = 12;
    localparam int IMM_SIGN    = 31;  // sign bit of every immediate

    // what fetch needs to know about a word
    typedef enum logic [2:0] {
        CLS_PLAIN   = 3'd0,
        CLS_JAL     = 3'd1,
        CLS_BRANCH  = 3'd2,
        CLS_JALR    = 3'd3,
        CLS_SYSTEM  = 3'd4,  // ecall / mret
        CLS_FENCE_I = 3'd5
    } instr_class_e;

endpackage

/* skid_buffer.sv */
module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i,
    input  logic     flush_i
);

    logic     valid_q;
    payload_t data_q;

    // room when empty or when the entry leaves this cycle
    assign in_ready_o  = ~valid_q | out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // drops incoming data too
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

/* tb_fetch.sv */
module tb_fetch import rv_isa_pkg::*, fetch_pkg::*;;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED           = 32'd53;
    localparam int          PROG_BASE      = 'h10;  // stim layout, see fetch_stim.txt
    localparam int          PROG_MAX       = 'h30;
    localparam int          OUT_BASE       = 'h40;

    typedef enum logic [1:0] {W_NONE, W_RESOLVE, W_FENCE} stall_e;

    logic            clk;
    logic            rst;
    logic            mem_req;
    logic [XLEN-1:0] mem_addr;
    logic            mem_gnt;
    logic            mem_rsp_valid;
    logic [31:0]     mem_rdata;
    logic            pkt_valid;
    fetch_pkt_t      pkt;
    logic            pkt_ready;
    resolve_t        resolve;
    logic            fence;
    logic            fence_done;
    logic [CNT_W-1:0] hit_cnt;
    logic [CNT_W-1:0] miss_cnt;

    logic [31:0] stim_mem [0:127];
    logic [31:0] prog_words;
    logic [31:0] out_count;

    // reference path state
    logic [31:0] model_pc;
    int          out_idx;
    stall_e      wait_kind;
    resolve_t    pend_resolve;

    fetch_unit fetch_unit_i (
        .clk             (clk),
        .rst             (rst),
        .mem_req_o       (mem_req),
        .mem_addr_o      (mem_addr),
        .mem_gnt_i       (mem_gnt),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rdata_i     (mem_rdata),
        .pkt_valid_o     (pkt_valid),
        .pkt_o           (pkt),
        .pkt_ready_i     (pkt_ready),
        .resolve_i       (resolve),
        .fence_o         (fence),
        .fence_done_i    (fence_done),
        .pred_hit_cnt_o  (hit_cnt),
        .pred_miss_cnt_o (miss_cnt)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr >= RESET_PC && idx < prog_words && addr[1:0] == 2'b00) begin
            return stim_mem[PROG_BASE + idx];
        end
        return {addr[24:0] ^ addr[31:7], 7'b001_0011};  // op-imm filler, plain class
    endfunction

    // opcode classes as the ISA defines them
    function automatic instr_class_e classify_word(input logic [31:0] w);
        instr_class_e c;
        c = CLS_PLAIN;
        if (w[6:0] == OPC_JAL) begin
            c = CLS_JAL;
        end else if (w[6:0] == OPC_BRANCH) begin
            c = CLS_BRANCH;
        end else if (w[6:0] == OPC_JALR) begin
            c = CLS_JALR;
        end else if (w[6:0] == OPC_SYSTEM && w[14:12] == 3'b000 &&
                     (w[31:20] == FUNCT12_ECALL || w[31:20] == FUNCT12_MRET)) begin
            c = CLS_SYSTEM;
        end else if (w[6:0] == OPC_MISC_MEM && w[14:12] == 3'b001) begin
            c = CLS_FENCE_I;
        end
        return c;
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic fetch_pkt_t expected_pkt(input logic [31:0] pc);
        fetch_pkt_t p;
        p.pc         = pc;
        p.instr      = fetch_word(pc);
        p.cls        = classify_word(p.instr);
        p.pred_taken = (p.cls == CLS_BRANCH) && p.instr[31];  // negative offset is backward
        return p;
    endfunction

    function automatic string pkt_text(input fetch_pkt_t p);
        return $sformatf("pc=%h instr=%h cls=%0d pred=%0b",
                         p.pc, p.instr, p.cls, p.pred_taken);
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR %s", msg);
        abort_run();
    endtask

    task automatic check_pkt(input string name, input fetch_pkt_t want, input fetch_pkt_t act);
        if (act !== want) begin
            $display("CHECK FAILED %s: expected %s, actual %s", name,
                     pkt_text(want), pkt_text(act));
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] want,
                               input logic [CNT_W-1:0] act);
        if (act !== want) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, want, act);
            abort_run();
        end
    endtask

    // next pc on the architectural path, plus what execute will answer
    task automatic advance_model(input fetch_pkt_t p);
        logic [31:0] seq_pc;
        logic [31:0] outcome;
        seq_pc = p.pc + 32'd4;
        case (p.cls)
            CLS_JAL: model_pc = p.pc + jal_offset(p.instr);
            CLS_BRANCH, CLS_JALR, CLS_SYSTEM: begin
                if (out_idx >= out_count) begin
                    report_failure("branch outcome list ran out");
                end
                outcome = stim_mem[OUT_BASE + out_idx];
                out_idx++;
                if (p.cls == CLS_BRANCH) begin
                    model_pc = outcome[0] ? p.pc + branch_offset(p.instr) : seq_pc;
                    pend_resolve.taken = outcome[0];
                end else begin
                    model_pc = outcome;  // jump target
                    pend_resolve.taken = 1'b1;
                end
                pend_resolve.valid  = 1'b1;
                pend_resolve.target = model_pc;
                wait_kind = W_RESOLVE;
            end
            CLS_FENCE_I: begin
                model_pc  = seq_pc;
                wait_kind = W_FENCE;
            end
            default: model_pc = seq_pc;
        endcase
    endtask

    // grant and response each 1 to 3 cycles late
    task automatic serve_memory();
        logic [31:0] rng;
        logic [31:0] addr;
        int          idle;
        rng = SEED;
        forever begin
            idle = 0;
            while (!mem_req) begin
                if (idle == TIMEOUT_CYCLES) begin
                    report_failure("no memory request within timeout");
                end
                idle++;
                step();
            end
            addr = mem_addr;
            rng  = xorshift32(rng);
            repeat (rng % 3) step();
            mem_gnt = 1'b1;
            step();
            mem_gnt = 1'b0;
            rng     = xorshift32(rng);
            repeat (rng % 3) step();
            mem_rsp_valid = 1'b1;
            mem_rdata     = fetch_word(addr);
            step();
            mem_rsp_valid = 1'b0;
        end
    endtask

    initial begin
        fetch_pkt_t  want;
        fetch_pkt_t  held;
        logic [31:0] rng;
        logic        stalled;
        int          stall_cnt;
        int          idle;
        int          pkt_seen;
        clk           = 1'b0;
        rst           = 1'b1;
        mem_gnt       = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        pkt_ready     = 1'b0;
        resolve       = '0;
        fence_done    = 1'b0;
        $readmemh("fetch_stim.txt", stim_mem);
        prog_words = stim_mem[0];
        out_count  = stim_mem[1];
        if (prog_words > PROG_MAX) begin
            report_failure("program in stim file is too large");
        end

        repeat (3) begin
            step();
            if (mem_req || pkt_valid || fence) begin
                report_failure("fetch outputs active during reset");
            end
        end
        rst = 1'b0;
        check_count("hit count after reset", '0, hit_cnt);
        check_count("miss count after reset", '0, miss_cnt);

        fork
            serve_memory();
        join_none

        model_pc  = RESET_PC;
        out_idx   = 0;
        wait_kind = W_NONE;
        stall_cnt = 0;
        stalled   = 1'b0;
        idle      = 0;
        pkt_seen  = 0;
        rng       = SEED;
        while (pkt_seen < stim_mem[4]) begin
            step();
            resolve    = '0;
            fence_done = 1'b0;
            idle++;
            if (idle > TIMEOUT_CYCLES) begin
                report_failure("no packet from the fetch unit within timeout");
            end
            if (stalled) begin  // decode held off last cycle
                if (!pkt_valid) begin
                    report_failure("pkt_valid_o dropped before the packet was taken");
                end
                check_pkt("stable pkt under back-pressure", held, pkt);
            end
            if (wait_kind != W_NONE) begin
                if (pkt_valid) begin
                    report_failure("packet issued before resolve or fence done");
                end
                if (wait_kind == W_FENCE && !fence) begin
                    report_failure("fence_o low while fence.i waits");
                end
                if (stall_cnt == 0) begin
                    if (wait_kind == W_RESOLVE) begin
                        resolve = pend_resolve;
                    end else begin
                        fence_done = 1'b1;
                    end
                    wait_kind = W_NONE;
                end else begin
                    stall_cnt--;
                end
            end
            rng       = xorshift32(rng);
            pkt_ready = (rng[1:0] != 2'b00);  // ready about 3 cycles in 4
            if (pkt_valid && pkt_ready) begin
                want = expected_pkt(model_pc);
                check_pkt($sformatf("packet %0d", pkt_seen), want, pkt);
                if (want.cls == CLS_FENCE_I && !fence) begin
                    report_failure("fence_o not raised with the fence.i packet");
                end
                advance_model(want);
                if (wait_kind != W_NONE) begin
                    rng       = xorshift32(rng);
                    stall_cnt = rng % 4;
                end
                pkt_seen++;
                idle = 0;
            end
            stalled = pkt_valid && !pkt_ready;
            held    = pkt;
        end

        check_count("branch hits", stim_mem[2], hit_cnt);
        check_count("branch misses", stim_mem[3], miss_cnt);
        if (out_idx != out_count) begin
            report_failure("not every branch outcome in the stim file was used");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule
